// ==== src.f ====
soc_map_pkg.sv
soc_bus_pkg.sv
wb_settings_slave.sv
misc_ctrl_regs.sv
vita_timer.sv
readback_mux.sv
ctrl_core.sv
tb_ctrl_core.sv

// ==== tb_ctrl_core.sv ====
// Self-checking testbench for the control core that stops at the first error.
// The ctrl_o and leds_o model is compared on every falling edge after reset.
`timescale 1ns/1ps

module tb_ctrl_core
   import soc_map_pkg::*, soc_bus_pkg::*;
;

   // About 100 accesses of 3 cycles each plus reset, with wide margin
   localparam int CYCLE_LIMIT = 3000;

   logic       dsp_clk;
   logic       rst_n;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   logic       run_tx;
   logic       run_rx;
   logic       clk_status;
   logic       link_up;
   ctrl_out_t  ctrl_o;
   logic [7:0] leds_o;

   // Reference register state, updated on the edge where the DUT loads
   logic [4:0] m_clk = '0;
   logic [3:0] m_ser = '0;
   logic [3:0] m_adc = '0;
   logic [7:0] m_sw  = '0;
   logic       m_phy = 1'b0;
   logic [7:0] m_src = LED_SRC_AT_RESET;

   string      test_name = "reset";
   logic       live_check = 1'b0;
   int         cycles = 0;

   ctrl_core i_ctrl_core (
      .dsp_clk      (dsp_clk),
      .rst_n_i      (rst_n),
      .wb_req_i     (wb_req),
      .wb_rsp_o     (wb_rsp),
      .run_tx_i     (run_tx),
      .run_rx_i     (run_rx),
      .clk_status_i (clk_status),
      .link_up_i    (link_up),
      .ctrl_o       (ctrl_o),
      .leds_o       (leds_o)
   );

   initial dsp_clk = 1'b0;
   always #2 dsp_clk = ~dsp_clk;

   ////////////////////////////////////////////////////
   // Reference model and checks

   // Field order of ctrl_out_t with PHY reset inverted
   function automatic ctrl_out_t expected_ctrl(input logic [4:0] clk_v, input logic [3:0] ser_v,
                                               input logic [3:0] adc_v, input logic phy_v);
      ctrl_out_t c;
      c = {clk_v, ser_v, adc_v, ~phy_v};
      return c;
   endfunction

   function automatic logic [7:0] led_mux_model(input logic [7:0] sw, input logic [7:0] src,
                                                input logic [3:0] hw_in);
      logic [7:0] hw;
      logic [7:0] leds;
      hw = {3'b000, hw_in, 1'b0};
      for (int i = 0; i < 8; i++) begin
         leds[i] = src[i] ? hw[i] : sw[i];
      end
      return leds;
   endfunction

   task automatic halt_with_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         halt_with_error($sformatf("FAIL %s %s expected %h actual %h",
                                   test_name, name, exp, act));
      end
   endtask

   // Only settings-window words reach the registers
   task automatic model_write(input int word, input logic [31:0] data);
      case (word)
         SR_MISC + SR_CLK_OFS:     m_clk = data[4:0];
         SR_MISC + SR_SER_OFS:     m_ser = data[3:0];
         SR_MISC + SR_ADC_OFS:     m_adc = data[3:0];
         SR_MISC + SR_LED_SW_OFS:  m_sw  = data[7:0];
         SR_MISC + SR_PHY_OFS:     m_phy = data[0];
         SR_MISC + SR_LED_SRC_OFS: m_src = data[7:0];
         default: ;
      endcase
   endtask

   always @(negedge dsp_clk) begin
      if (live_check) begin
         compare_word("ctrl_o", 32'(expected_ctrl(m_clk, m_ser, m_adc, m_phy)),
                      32'(ctrl_o));
         compare_word("leds_o",
                      32'(led_mux_model(m_sw, m_src, {run_tx, run_rx, clk_status, link_up})),
                      32'(leds_o));
      end
   end

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         halt_with_error("Timeout: the run did not finish within the cycle limit");
      end
   end

   ////////////////////////////////////////////////////
   // Wishbone master

   // One access with ack expected exactly one cycle after stb
   task automatic bus_access(input int word, input logic we, input logic [31:0] data,
                             output logic [31:0] rdata);
      int waits;
      @(posedge dsp_clk);
      wb_req.cyc <= 1'b1;
      wb_req.stb <= 1'b1;
      wb_req.we  <= we;
      wb_req.adr <= WB_AW'(word * 4);
      wb_req.sel <= 4'hF;
      wb_req.dat <= data;
      waits = 0;
      do begin
         @(negedge dsp_clk);
         waits++;
      end while (!wb_rsp.ack);
      assert (waits == 2) else halt_with_error("Wishbone ack did not come one cycle after stb");
      rdata = wb_rsp.dat;
      @(posedge dsp_clk);
      wb_req.cyc <= 1'b0;
      wb_req.stb <= 1'b0;
      wb_req.we  <= 1'b0;
      if (we) begin
         model_write(word, data);
      end
      @(negedge dsp_clk);
      assert (!wb_rsp.ack) else halt_with_error("Wishbone ack stayed high for a second cycle");
   endtask

   task automatic bus_write(input int word, input logic [31:0] data);
      logic [31:0] unused;
      bus_access(word, 1'b1, data, unused);
   endtask

   task automatic bus_read(input int word, output logic [31:0] rdata);
      bus_access(word, 1'b0, 32'd0, rdata);
   endtask

   ////////////////////////////////////////////////////
   // Test sequence
   initial begin
      int          ctrl_words[4];
      logic [31:0] rd;
      logic [31:0] hi_load;
      logic [31:0] lo_load;
      ctrl_out_t   held_ctrl;
      logic [7:0]  held_leds;
      void'($urandom(47));
      ctrl_words = '{SR_MISC + SR_CLK_OFS, SR_MISC + SR_SER_OFS,
                     SR_MISC + SR_ADC_OFS, SR_MISC + SR_PHY_OFS};
      wb_req     = '0;
      rst_n      = 1'b0;
      {run_tx, run_rx, clk_status, link_up} = 4'hF;
      repeat (4) @(posedge dsp_clk);
      rst_n <= 1'b1;
      @(negedge dsp_clk);
      compare_word("ctrl_o", 32'h0000_0001, 32'(ctrl_o));
      compare_word("leds_o", 32'(LED_SRC_AT_RESET), 32'(leds_o));
      live_check = 1'b1;

      test_name = "control writes";
      for (int n = 0; n < 20; n++) begin
         bus_write(ctrl_words[$urandom % 4], $urandom);
         bus_read(RB_WINDOW + RB_CTRL, rd);
         compare_word("control readback", 32'(expected_ctrl(m_clk, m_ser, m_adc, m_phy)), rd);
      end

      test_name = "led mux";
      for (int n = 0; n < 16; n++) begin
         @(posedge dsp_clk);
         {run_tx, run_rx, clk_status, link_up} <= 4'($urandom);
         bus_write(SR_MISC + SR_LED_SW_OFS, $urandom);
         bus_write(SR_MISC + SR_LED_SRC_OFS, $urandom);
      end

      test_name = "fixed readback";
      bus_read(RB_WINDOW + RB_COMPAT, rd);
      compare_word("compat number", 32'h0007_0001, rd);
      for (int n = 0; n < 4; n++) begin
         @(posedge dsp_clk);
         {clk_status, link_up} <= 2'(n);
         bus_read(RB_WINDOW + RB_HW_STATUS, rd);
         compare_word("hw status", 32'(n), rd);
      end
      for (int idx = 5; idx < 16; idx++) begin
         bus_read(RB_WINDOW + idx, rd);
         compare_word("unmapped readback", 32'd0, rd);
      end
      bus_read(SR_MISC + SR_CLK_OFS, rd);
      compare_word("settings window read", 32'd0, rd);
      bus_read(SR_TIME64, rd);
      compare_word("settings window read", 32'd0, rd);

      // Low word kept well below wrap so the high word cannot carry
      test_name = "time load";
      hi_load = $urandom;
      lo_load = 32'h1000_0000 | ($urandom & 32'h0FFF_FFFF);
      bus_write(SR_TIME64 + TIME_HI_OFS, hi_load);
      bus_write(SR_TIME64 + TIME_LO_OFS, lo_load);
      bus_write(SR_TIME64 + TIME_IMM_OFS, 32'd0);
      bus_read(RB_WINDOW + RB_TIME_HI, rd);
      compare_word("time high word", hi_load, rd);
      bus_read(RB_WINDOW + RB_TIME_LO, rd);
      assert ((rd - lo_load >= 1) && (rd - lo_load <= 50)) else begin
         halt_with_error($sformatf("FAIL %s time low word expected %h plus 1 to 50 actual %h",
                                   test_name, lo_load, rd));
      end

      // Data differs from the registers these words would alias onto by low address bits
      test_name = "ignored writes";
      held_ctrl = ctrl_o;
      held_leds = leds_o;
      bus_write(RB_WINDOW + RB_CTRL, 32'(~m_phy));
      bus_write(RB_WINDOW + RB_COMPAT, 32'(~m_clk));
      compare_word("ignored write ctrl_o", 32'(held_ctrl), 32'(ctrl_o));
      compare_word("ignored write leds_o", 32'(held_leds), 32'(leds_o));

      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== ctrl_core.sv ====
// Control and status core on dsp_clk: Wishbone slave, settings registers,
// VITA time and readback. One access per two cycles at most.
`timescale 1ns/1ps

module ctrl_core
   import soc_bus_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       rst_n_i,

   // Host bus
   input  wb_req_t    wb_req_i,
   output wb_rsp_t    wb_rsp_o,

   // Hardware status
   input  logic       run_tx_i,
   input  logic       run_rx_i,
   input  logic       clk_status_i,
   input  logic       link_up_i,

   // Board control
   output ctrl_out_t  ctrl_o,
   output logic [7:0] leds_o
);

   logic        wb_ack;
   set_bus_t    set_bus;
   rb_req_t     rb_req;
   ctrl_out_t   ctrl;
   logic [63:0] vita_time;
   logic [31:0] rd_dat;

   //////////////////////////////////////////////////
   // Stage 1, bus slave
   wb_settings_slave i_wb_settings_slave (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .wb_req_i  (wb_req_i),
      .wb_ack_o  (wb_ack),
      .set_bus_o (set_bus),
      .rb_req_o  (rb_req)
   );

   //////////////////////////////////////////////////
   // Stage 2, registers and time
   misc_ctrl_regs i_misc_ctrl_regs (
      .dsp_clk      (dsp_clk),
      .rst_n_i      (rst_n_i),
      .set_bus_i    (set_bus),
      .run_tx_i     (run_tx_i),
      .run_rx_i     (run_rx_i),
      .clk_status_i (clk_status_i),
      .link_up_i    (link_up_i),
      .ctrl_o       (ctrl),
      .leds_o       (leds_o)
   );

   vita_timer i_vita_timer (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .set_bus_i (set_bus),
      .time_o    (vita_time)
   );

   //////////////////////////////////////////////////
   // Stage 3, readback
   readback_mux i_readback_mux (
      .dsp_clk      (dsp_clk),
      .rst_n_i      (rst_n_i),
      .rb_req_i     (rb_req),
      .time_i       (vita_time),
      .ctrl_i       (ctrl),
      .clk_status_i (clk_status_i),
      .link_up_i    (link_up_i),
      .rd_dat_o     (rd_dat)
   );

   assign ctrl_o       = ctrl;
   assign wb_rsp_o.ack = wb_ack;
   assign wb_rsp_o.dat = rd_dat;

endmodule

// ==== readback_mux.sv ====
// Registered readback word select, data is valid only in the ack cycle.
// Reading the high time word freezes the low word for the next read.
`timescale 1ns/1ps

module readback_mux
   import soc_map_pkg::*, soc_bus_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        rst_n_i,
   input  rb_req_t     rb_req_i,
   input  logic [63:0] time_i,
   input  ctrl_out_t   ctrl_i,
   input  logic        clk_status_i,
   input  logic        link_up_i,
   output logic [31:0] rd_dat_o
);

   logic [31:0] word_sel;
   logic [31:0] snap_lo;

   //////////////////////////////////////////////////
   // Word select
   always_comb begin
      case (rb_req_i.idx)
         RB_IDX_W'(RB_COMPAT): begin
            word_sel = COMPAT_NUM;
         end
         RB_IDX_W'(RB_TIME_HI): begin
            word_sel = time_i[63:32];
         end
         RB_IDX_W'(RB_TIME_LO): begin
            word_sel = snap_lo;
         end
         RB_IDX_W'(RB_HW_STATUS): begin
            word_sel = {30'd0, clk_status_i, link_up_i};
         end
         RB_IDX_W'(RB_CTRL): begin
            word_sel = 32'(ctrl_i);
         end
         default: begin
            word_sel = '0;
         end
      endcase
   end

   // Low half captured with the high half, so hi then lo is coherent
   always_ff @(posedge dsp_clk) begin
      if (rb_req_i.stb && (rb_req_i.idx == RB_IDX_W'(RB_TIME_HI))) begin
         snap_lo <= time_i[31:0];
      end
   end

   //////////////////////////////////////////////////
   // Output register, zero outside readback requests
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         rd_dat_o <= '0;
      end else if (rb_req_i.stb) begin
         rd_dat_o <= word_sel;
      end else begin
         rd_dat_o <= '0;
      end
   end

endmodule

// ==== vita_timer.sv ====
// 64-bit VITA time, counts one per dsp_clk cycle.
// Write high and low words first; the immediate write then loads them both.
`timescale 1ns/1ps

module vita_timer
   import soc_map_pkg::*, soc_bus_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        rst_n_i,
   input  set_bus_t    set_bus_i,
   output logic [63:0] time_o
);

   logic        hit_hi;
   logic        hit_lo;
   logic        hit_imm;
   logic [31:0] pend_hi;
   logic [31:0] pend_lo;
   logic [63:0] time_q;

   //////////////////////////////////////////////////
   // Register decode
   assign hit_hi  = set_bus_i.stb &&
                    (set_bus_i.addr == SET_AW'(SR_TIME64 + TIME_HI_OFS));
   assign hit_lo  = set_bus_i.stb &&
                    (set_bus_i.addr == SET_AW'(SR_TIME64 + TIME_LO_OFS));
   assign hit_imm = set_bus_i.stb &&
                    (set_bus_i.addr == SET_AW'(SR_TIME64 + TIME_IMM_OFS));

   // Pending load value
   always_ff @(posedge dsp_clk) begin
      if (hit_hi) begin
         pend_hi <= set_bus_i.data;
      end
      if (hit_lo) begin
         pend_lo <= set_bus_i.data;
      end
   end

   //////////////////////////////////////////////////
   // Counter
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         time_q <= '0;
      end else if (hit_imm) begin
         time_q <= {pend_hi, pend_lo};
      end else begin
         time_q <= time_q + 64'd1;
      end
   end

   assign time_o = time_q;

endmodule

// ==== misc_ctrl_regs.sv ====
// Miscellaneous control registers and the LED source mux.
// PHY reset is stored active high and leaves the core active low.
`timescale 1ns/1ps

module misc_ctrl_regs
   import soc_map_pkg::*, soc_bus_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      rst_n_i,
   input  set_bus_t  set_bus_i,
   input  logic      run_tx_i,
   input  logic      run_rx_i,
   input  logic      clk_status_i,
   input  logic      link_up_i,
   output ctrl_out_t ctrl_o,
   output logic [7:0] leds_o
);

   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic [7:0] led_sw;
   logic       phy_reg;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   //////////////////////////////////////////////////
   // Setting registers
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         clk_reg <= '0;
         ser_reg <= '0;
         adc_reg <= '0;
         led_sw  <= '0;
         phy_reg <= 1'b0;
         led_src <= LED_SRC_AT_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            SET_AW'(SR_MISC + SR_CLK_OFS): begin
               clk_reg <= set_bus_i.data[4:0];
            end
            SET_AW'(SR_MISC + SR_SER_OFS): begin
               ser_reg <= set_bus_i.data[3:0];
            end
            SET_AW'(SR_MISC + SR_ADC_OFS): begin
               adc_reg <= set_bus_i.data[3:0];
            end
            SET_AW'(SR_MISC + SR_LED_SW_OFS): begin
               led_sw <= set_bus_i.data[7:0];
            end
            SET_AW'(SR_MISC + SR_PHY_OFS): begin
               phy_reg <= set_bus_i.data[0];
            end
            SET_AW'(SR_MISC + SR_LED_SRC_OFS): begin
               led_src <= set_bus_i.data[7:0];
            end
            default: begin
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Control line mapping
   always_comb begin
      ctrl_o.clock_ready = clk_reg[4];
      ctrl_o.clk_en      = clk_reg[3:2];
      ctrl_o.clk_sel     = clk_reg[1:0];
      ctrl_o.ser_enable  = ser_reg[3];
      ctrl_o.ser_prbsen  = ser_reg[2];
      ctrl_o.ser_loopen  = ser_reg[1];
      ctrl_o.ser_rx_en   = ser_reg[0];
      ctrl_o.adc_oe_a    = adc_reg[3];
      ctrl_o.adc_on_a    = adc_reg[2];
      ctrl_o.adc_oe_b    = adc_reg[1];
      ctrl_o.adc_on_b    = adc_reg[0];
      ctrl_o.phy_reset_n = ~phy_reg;
   end

   //////////////////////////////////////////////////
   // LEDs, source bit 1 selects hardware
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// ==== wb_settings_slave.sv ====
// Wishbone classic slave, every access is acknowledged one cycle after stb.
// Writes with no byte lane selected and accesses outside both windows are acked only.
`timescale 1ns/1ps

module wb_settings_slave
   import soc_map_pkg::*, soc_bus_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     rst_n_i,
   input  wb_req_t  wb_req_i,
   output logic     wb_ack_o,
   output set_bus_t set_bus_o,
   output rb_req_t  rb_req_o
);

   logic               ack_q;
   logic               access;
   logic [WORD_AW-1:0] word_idx;
   logic [WORD_AW-1:0] rb_ofs;
   logic               in_set;
   logic               in_rb;

   logic               set_stb_q;
   logic [SET_AW-1:0]  set_addr_q;
   logic [WB_DW-1:0]   set_data_q;

   //////////////////////////////////////////////////
   // Address decode
   assign access   = wb_req_i.cyc && wb_req_i.stb && !ack_q;
   assign word_idx = wb_req_i.adr[WB_AW-1:2];
   assign rb_ofs   = word_idx - WORD_AW'(RB_WINDOW);
   assign in_set   = (word_idx < RB_WINDOW);
   // Readback window is 2**RB_IDX_W words long
   assign in_rb    = !in_set && (rb_ofs < (2 ** RB_IDX_W));

   //////////////////////////////////////////////////
   // Handshake and settings strobe
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         ack_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         ack_q     <= access;
         set_stb_q <= access && wb_req_i.we && in_set && (wb_req_i.sel != '0);
      end
   end

   // Address and data only matter while the strobe is up
   always_ff @(posedge dsp_clk) begin
      if (access) begin
         set_addr_q <= SET_AW'(word_idx);
         set_data_q <= wb_req_i.dat;
      end
   end

   always_comb begin
      set_bus_o.stb  = set_stb_q;
      set_bus_o.addr = set_addr_q;
      set_bus_o.data = set_data_q;
   end

   // Readback stage registers the word on the same edge as ack
   always_comb begin
      rb_req_o.stb = access && !wb_req_i.we && in_rb;
      rb_req_o.idx = rb_ofs[RB_IDX_W-1:0];
   end

   assign wb_ack_o = ack_q;

endmodule

// ==== soc_bus_pkg.sv ====
// Bus and control-line record types shared by every stage of the core.
// Field widths follow the address map package.

package soc_bus_pkg;

   import soc_map_pkg::*;

   //////////////////////////////////////////////////
   // Wishbone classic request from the host
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [WB_AW-1:0]  adr;
      logic [WB_SW-1:0]  sel;
      logic [WB_DW-1:0]  dat;
   } wb_req_t;

   // Response back to the host
   typedef struct packed {
      logic              ack;
      logic [WB_DW-1:0]  dat;
   } wb_rsp_t;

   //////////////////////////////////////////////////
   // Settings bus, stb is a one-cycle pulse
   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [WB_DW-1:0]  data;
   } set_bus_t;

   // Readback word request
   typedef struct packed {
      logic                stb;
      logic [RB_IDX_W-1:0] idx;
   } rb_req_t;

   //////////////////////////////////////////////////
   // Board control lines
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
   } ctrl_out_t;

endpackage

// ==== soc_map_pkg.sv ====
// Address map and register indices of the control core.
// The Wishbone address is a byte address; only full 32-bit words are decoded.

package soc_map_pkg;

   //////////////////////////////////////////////////
   // Bus widths
   localparam int WB_AW    = 10;
   localparam int WB_DW    = 32;
   localparam int WB_SW    = 4;
   localparam int WORD_AW  = WB_AW - 2;
   localparam int SET_AW   = 8;
   localparam int RB_IDX_W = 4;

   // Word index where the readback window begins
   localparam int RB_WINDOW = 128;

   //////////////////////////////////////////////////
   // Settings register indices
   localparam int SR_MISC        = 0;
   localparam int SR_CLK_OFS     = 0;
   localparam int SR_SER_OFS     = 1;
   localparam int SR_ADC_OFS     = 2;
   localparam int SR_LED_SW_OFS  = 3;
   localparam int SR_PHY_OFS     = 4;
   localparam int SR_LED_SRC_OFS = 6;

   // LEDs 1 to 4 follow hardware after reset
   localparam logic [7:0] LED_SRC_AT_RESET = 8'h1E;

   localparam int SR_TIME64    = 10;
   localparam int TIME_HI_OFS  = 0;
   localparam int TIME_LO_OFS  = 1;
   localparam int TIME_IMM_OFS = 2;

   //////////////////////////////////////////////////
   // Readback word indices
   localparam int RB_COMPAT    = 0;
   localparam int RB_TIME_HI   = 1;
   localparam int RB_TIME_LO   = 2;
   localparam int RB_HW_STATUS = 3;
   localparam int RB_CTRL      = 4;

   // Major in the upper half, minor in the lower half
   localparam logic [31:0] COMPAT_NUM = {16'd7, 16'd1};

endpackage
